//--- src/spu_cfg_pkg.sv
`default_nettype none

package spu_cfg_pkg;

    // ----------------------------------------------------------------------
    //  datapath widths
    // ----------------------------------------------------------------------

    localparam int data_bits    = 16;   // operand register and write data
    localparam int acc_bits     = 24;   // accumulator
    localparam int imm_bits     = 12;   // signed immediate field
    localparam int ctrl_bits    = 4;    // clear, sub, use_carry, imm_form

    // ----------------------------------------------------------------------
    //  operand register file
    // ----------------------------------------------------------------------

    localparam int reg_count    = 4;
    localparam int reg_idx_bits = 2;

    // unused bits in the register form of an instruction
    localparam int reg_pad_bits = data_bits - ctrl_bits - reg_idx_bits;

endpackage

`default_nettype wire

//--- src/spu_types_pkg.sv
`default_nettype none

package spu_types_pkg;

    import spu_cfg_pkg::*;

    // control field, common to both instruction forms
    typedef struct packed {
        logic   clear;      // start from zero
        logic   sub;        // subtract instead of add
        logic   use_carry;  // chain the stored carry / borrow
        logic   imm_form;   // 1: immediate view, 0: register view
    } spu_ctrl_t;

    typedef struct packed {
        spu_ctrl_t                  ctrl;
        logic signed [imm_bits-1:0] imm;
    } spu_imm_view_t;

    typedef struct packed {
        spu_ctrl_t                  ctrl;
        logic [reg_pad_bits-1:0]    pad;
        logic [reg_idx_bits-1:0]    idx;
    } spu_reg_view_t;

    // one 16-bit instruction word, read through either view
    typedef union packed {
        spu_imm_view_t  imm_v;
        spu_reg_view_t  reg_v;
    } spu_instr_t;

    // decode -> accumulate
    typedef struct packed {
        logic                   clear;
        logic                   sub;
        logic                   use_carry;
        logic [acc_bits-1:0]    operand;    // already sign-extended
    } acc_op_t;

    typedef struct packed {
        logic [acc_bits-1:0]    data;
        logic                   carry;
        logic                   zero;
        logic                   negative;
    } acc_result_t;

endpackage

`default_nettype wire

//--- src/spu_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_decode (
    input  var logic                                clk,
    input  var logic                                reset,
    input  var logic                                cke,

    input  var logic                                reg_write,
    input  var logic [spu_cfg_pkg::reg_idx_bits-1:0] reg_addr,
    input  var logic [spu_cfg_pkg::data_bits-1:0]   reg_data,

    input  var logic                                instr_valid,
    input  var spu_types_pkg::spu_instr_t           instr,

    output var logic                                op_valid,
    output var spu_types_pkg::acc_op_t              op
);

    import spu_cfg_pkg::*;
    import spu_types_pkg::*;

    // ----------------------------------------------------------------------
    //  operand registers
    // ----------------------------------------------------------------------

    logic [data_bits-1:0]   reg_file [reg_count];

    always_ff @(posedge clk) begin
        if (cke && reg_write) begin
            reg_file[reg_addr] <= reg_data;
        end
    end

    // ----------------------------------------------------------------------
    //  decode and operand select
    // ----------------------------------------------------------------------

    spu_ctrl_t              ctrl;
    logic [data_bits-1:0]   rd_data;
    logic [acc_bits-1:0]    operand;

    assign ctrl    = instr.imm_v.ctrl;          // same bits in both views
    assign rd_data = reg_file[instr.reg_v.idx]; // old value on same-cycle write

    always_comb begin
        if (ctrl.imm_form) begin
            operand = {{(acc_bits - imm_bits){instr.imm_v.imm[imm_bits-1]}},
                       instr.imm_v.imm};
        end
        else begin
            operand = {{(acc_bits - data_bits){rd_data[data_bits-1]}}, rd_data};
        end
    end

    // ----------------------------------------------------------------------
    //  output register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end
        else if (cke) begin
            op_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            op.clear     <= ctrl.clear;
            op.sub       <= ctrl.sub;
            op.use_carry <= ctrl.use_carry;
            op.operand   <= operand;
        end
    end

endmodule

`default_nettype wire

//--- src/spu_op_acc.sv
`timescale 1ns/1ps
`default_nettype none

module spu_op_acc (
    input  var logic                            clk,
    input  var logic                            reset,
    input  var logic                            cke,

    input  var logic                            op_valid,
    input  var spu_types_pkg::acc_op_t          op,

    output var logic                            acc_valid,
    output var logic [spu_cfg_pkg::acc_bits-1:0] acc_data,
    output var logic                            acc_carry
);

    import spu_cfg_pkg::*;

    // ----------------------------------------------------------------------
    //  operand preparation
    // ----------------------------------------------------------------------

    logic [acc_bits-1:0]    base;
    logic                   carry_in;

    // clear restarts from zero, otherwise keep accumulating
    assign base     = op.clear ? '0 : acc_data;
    assign carry_in = op.use_carry & acc_carry;

    // ----------------------------------------------------------------------
    //  adder / subtractor
    // ----------------------------------------------------------------------

    // one extra bit on top catches carry out or borrow
    logic [acc_bits:0]      add_wide;
    logic [acc_bits:0]      sub_wide;
    logic [acc_bits-1:0]    next_data;
    logic                   next_carry;

    always_comb begin
        add_wide = {1'b0, base} + {1'b0, op.operand} + {{acc_bits{1'b0}}, carry_in};
        sub_wide = {1'b0, base} - {1'b0, op.operand} - {{acc_bits{1'b0}}, carry_in};
    end

    always_comb begin
        if (op.sub) begin
            next_data  = sub_wide[acc_bits-1:0];
            next_carry = sub_wide[acc_bits];    // borrow
        end
        else begin
            next_data  = add_wide[acc_bits-1:0];
            next_carry = add_wide[acc_bits];    // carry out of msb
        end
    end

    // ----------------------------------------------------------------------
    //  accumulator state
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_data  <= '0;
            acc_carry <= 1'b0;
        end
        else if (cke && op_valid) begin
            acc_data  <= next_data;
            acc_carry <= next_carry;
        end
    end

    // one pulse per updated value, held while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_valid <= 1'b0;
        end
        else if (cke) begin
            acc_valid <= op_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/spu_result_out.sv
`timescale 1ns/1ps
`default_nettype none

module spu_result_out (
    input  var logic                            clk,
    input  var logic                            reset,
    input  var logic                            cke,

    input  var logic                            acc_valid,
    input  var logic [spu_cfg_pkg::acc_bits-1:0] acc_data,
    input  var logic                            acc_carry,

    output var logic                            result_valid,
    output var spu_types_pkg::acc_result_t      result
);

    import spu_cfg_pkg::*;
    import spu_types_pkg::*;

    // ----------------------------------------------------------------------
    //  flag generation
    // ----------------------------------------------------------------------

    acc_result_t    next_result;

    always_comb begin
        next_result.data     = acc_data;
        next_result.carry    = acc_carry;
        next_result.zero     = (acc_data == '0);
        next_result.negative = acc_data[acc_bits-1];    // sign bit
    end

    // ----------------------------------------------------------------------
    //  output register
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end
        else if (cke) begin
            result_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

//--- src/spu_acc_lane.sv
`timescale 1ns/1ps
`default_nettype none

module spu_acc_lane (
    input  var logic                                clk,
    input  var logic                                reset,
    input  var logic                                cke,

    input  var logic                                reg_write,
    input  var logic [spu_cfg_pkg::reg_idx_bits-1:0] reg_addr,
    input  var logic [spu_cfg_pkg::data_bits-1:0]   reg_data,

    input  var logic                                instr_valid,
    input  var spu_types_pkg::spu_instr_t           instr,

    output var logic                                result_valid,
    output var spu_types_pkg::acc_result_t          result
);

    import spu_cfg_pkg::*;
    import spu_types_pkg::*;

    // decode -> accumulate
    logic                   op_valid;
    acc_op_t                op;

    // accumulate -> output
    logic                   acc_valid;
    logic [acc_bits-1:0]    acc_data;
    logic                   acc_carry;

    spu_op_decode i_decode (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_data       (reg_data),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .op_valid       (op_valid),
        .op             (op)
    );

    spu_op_acc i_acc (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .op_valid       (op_valid),
        .op             (op),
        .acc_valid      (acc_valid),
        .acc_data       (acc_data),
        .acc_carry      (acc_carry)
    );

    spu_result_out i_out (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .acc_valid      (acc_valid),
        .acc_data       (acc_data),
        .acc_carry      (acc_carry),
        .result_valid   (result_valid),
        .result         (result)
    );

endmodule

`default_nettype wire

//--- verification/spu_acc_lane_props.sv
`timescale 1ns/1ps
`default_nettype none

module spu_acc_lane_props (
    input  var logic                        clk,
    input  var logic                        reset,
    input  var logic                        cke,
    input  var logic                        instr_valid,
    input  var logic                        result_valid,
    input  var spu_types_pkg::acc_result_t  result
);

    import spu_cfg_pkg::*;

    // accepted instructions, one bit per pipeline stage
    logic [2:0] in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end
        else if (cke) begin
            in_flight <= {in_flight[1:0], instr_valid};
        end
    end

    // ----------------------------------------------------------------------
    //  properties
    // ----------------------------------------------------------------------

    quiet_in_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high during reset or in the cycle after it");

    stall_holds: assert property (@(posedge clk) disable iff (reset)
        !cke |=> $stable(result_valid) && $stable(result))
        else $error("result changed across a stalled edge");

    // three enabled edges from accept to result
    latency_three: assert property (@(posedge clk) disable iff (reset)
        result_valid == in_flight[2])
        else $error("result_valid does not follow three enabled edges after instr_valid");

    sign_flag: assert property (@(posedge clk) disable iff (reset)
        result.negative == result.data[acc_bits-1])
        else $error("negative flag differs from the sign bit of the result data");

endmodule

`default_nettype wire

//--- verification/tb_spu_acc_lane.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spu_acc_lane;

    import spu_cfg_pkg::*;
    import spu_types_pkg::*;

    localparam int clk_half     = 50;
    localparam int accept_limit = 50;   // cycles a vector may wait for cke
    localparam int drain_limit  = 200;

    typedef struct packed {
        int             line_no;
        acc_result_t    res;
    } expect_t;

    logic                       clk;
    logic                       reset;
    logic                       cke;
    logic                       reg_write;
    logic [reg_idx_bits-1:0]    reg_addr;
    logic [data_bits-1:0]       reg_data;
    logic                       instr_valid;
    spu_instr_t                 instr;
    logic                       result_valid;
    acc_result_t                result;

    expect_t                    expected [$];

    spu_acc_lane i_dut (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .reg_write      (reg_write),
        .reg_addr       (reg_addr),
        .reg_data       (reg_data),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .result_valid   (result_valid),
        .result         (result)
    );

    bind spu_acc_lane spu_acc_lane_props i_props (
        .clk            (clk),
        .reset          (reset),
        .cke            (cke),
        .instr_valid    (instr_valid),
        .result_valid   (result_valid),
        .result         (result)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ----------------------------------------------------------------------
    //  checking
    // ----------------------------------------------------------------------

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input int line_no, input string field,
                                   input string exp_s, input string act_s);
        $display("error: line %0d %s expected %s actual %s", line_no, field, exp_s, act_s);
        abort_run();
    endtask

    task automatic check_result();
        expect_t item;
        assert (expected.size() != 0) else begin
            $display("result_valid pulsed with no instruction outstanding");
            abort_run();
        end
        item = expected.pop_front();
        assert (result.data == item.res.data) else begin
            report_mismatch(item.line_no, "data", $sformatf("%h", item.res.data),
                            $sformatf("%h", result.data));
        end
        assert (result.carry == item.res.carry) else begin
            report_mismatch(item.line_no, "carry", $sformatf("%b", item.res.carry),
                            $sformatf("%b", result.carry));
        end
        assert (result.zero == item.res.zero) else begin
            report_mismatch(item.line_no, "zero", $sformatf("%b", item.res.zero),
                            $sformatf("%b", result.zero));
        end
        assert (result.negative == item.res.negative) else begin
            report_mismatch(item.line_no, "negative", $sformatf("%b", item.res.negative),
                            $sformatf("%b", result.negative));
        end
    endtask

    // cke drops about one cycle in ten
    initial begin
        void'($urandom(32'h2998_2a6f));
        cke = 1'b1;
        forever begin
            @(negedge clk);
            if (cke && result_valid) begin   // new only if the last edge was enabled
                check_result();
            end
            cke = ($urandom_range(9) != 0);
        end
    end

    // ----------------------------------------------------------------------
    //  stimulus
    // ----------------------------------------------------------------------

    initial begin : stimulus
        int                         fd;
        int                         line_no;
        int                         n_fields;
        int                         waited;
        string                      text;
        expect_t                    item;
        logic                       f_wr;
        logic [reg_idx_bits-1:0]    f_addr;
        logic [data_bits-1:0]       f_wdata;
        logic                       f_iv;
        logic [data_bits-1:0]       f_word;
        logic [acc_bits-1:0]        f_data;
        logic                       f_carry;
        logic                       f_zero;
        logic                       f_neg;

        reset       = 1'b1;
        reg_write   = 1'b0;
        reg_addr    = '0;
        reg_data    = '0;
        instr_valid = 1'b0;
        instr       = '0;
        line_no     = 0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("verification/spu_acc_input.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file");
            abort_run();
        end

        while ($fgets(text, fd) != 0) begin
            line_no++;
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n_fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h", f_wr, f_addr, f_wdata,
                               f_iv, f_word, f_data, f_carry, f_zero, f_neg);
            assert (n_fields == 9) else begin
                $display("stimulus line %0d does not hold nine fields", line_no);
                abort_run();
            end

            @(negedge clk);
            reg_write   = f_wr;
            reg_addr    = f_addr;
            reg_data    = f_wdata;
            instr_valid = f_iv;
            instr       = f_word;

            // hold until an enabled edge takes the vector
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (!cke && waited >= accept_limit) begin
                    $display("cke stayed low, line %0d was never accepted", line_no);
                    abort_run();
                end
            end while (!cke);

            if (f_iv) begin
                item.line_no      = line_no;
                item.res.data     = f_data;
                item.res.carry    = f_carry;
                item.res.zero     = f_zero;
                item.res.negative = f_neg;
                expected.push_back(item);
            end
        end
        $fclose(fd);

        @(negedge clk);
        reg_write   = 1'b0;
        instr_valid = 1'b0;

        waited = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit) begin
                $display("results stopped arriving, %0d still outstanding", expected.size());
                abort_run();
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/spu_cfg_pkg.sv
src/spu_types_pkg.sv
src/spu_op_decode.sv
src/spu_op_acc.sv
src/spu_result_out.sv
src/spu_acc_lane.sv
verification/spu_acc_lane_props.sv
verification/tb_spu_acc_lane.sv

//--- Makefile
# Verilator build and run for the accumulator lane

VERILATOR ?= verilator
TOP       ?= tb_spu_acc_lane
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES   := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# status comes from the pass line in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/spu_acc_input.txt
# wr addr wdata iv instr | exp_data carry zero negative, all hex
# expected fields are only checked on lines with iv = 1
0 0 0000 1 9800 fff800 0 0 1
0 0 0000 1 17ff ffffff 0 0 1
0 0 0000 1 1005 000004 1 0 0
0 0 0000 1 3001 000006 0 0 0
0 0 0000 1 97ff 0007ff 0 0 0
0 0 0000 1 17ff 000ffe 0 0 0
0 0 0000 1 d001 ffffff 1 0 1
0 0 0000 1 7002 fffffc 0 0 1
0 0 0000 1 9005 000005 0 0 0
0 0 0000 1 5005 000000 0 1 0
0 0 0000 1 7001 ffffff 1 0 1
0 0 0000 1 7000 fffffe 0 0 1
1 0 1234 0 0000 000000 0 0 0
1 1 8000 0 0000 000000 0 0 0
1 2 00ff 0 0000 000000 0 0 0
1 3 ffff 0 0000 000000 0 0 0
0 0 0000 1 8000 001234 0 0 0
0 0 0000 1 8001 ff8000 0 0 1
0 0 0000 1 8002 0000ff 0 0 0
0 0 0000 1 0003 0000fe 1 0 0
1 0 0001 1 8000 001234 0 0 0
0 0 0000 1 8000 000001 0 0 0
0 0 0000 1 4002 ffff02 1 0 1
1 3 0000 1 c003 000001 1 0 0
0 0 0000 1 2003 000002 0 0 0
0 0 0000 1 8ff1 ff8000 0 0 1
0 0 0000 1 1800 ff7800 1 0 1
0 0 0000 0 0000 000000 0 0 0
